// ==== logic/corr_defs.svh ====
// Line count, lag count and accumulator width of the correlator.
// Frame header byte.
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

`default_nettype none

// number of sampled input lines.
`define CORR_LINES 4

// autocorrelation lags 1 to CORR_LAGS.
`define CORR_LAGS 4

// saturating accumulator width.
`define CORR_RES 16

// first byte of every frame.
`define CORR_HDR 8'hA5

`default_nettype wire

`endif

// ==== logic/corr_pkg.sv ====
// Packed struct types shared by the datapath and the checker.
// ctrl_t, sample_t, counts_t, lags_t and frame_t.
`include "corr_defs.svh"
`default_nettype none

package corr_pkg;

	typedef struct packed {
		logic [`CORR_LINES-1:0] inv_mask; // per-line inversion.
		logic [`CORR_LINES-1:0] edge_mask; // per-line change detection.
		logic                   integrating;
		logic                   clear; // one cycle.
		logic                   send; // one cycle.
	} ctrl_t;

	typedef struct packed {
		logic [`CORR_LINES-1:0] bits;
		logic                   gate; // sample counts when high.
	} sample_t;

	// line 0 sits in the most significant word.
	typedef struct packed {
		logic [0:`CORR_LINES-1][`CORR_RES-1:0] cnt;
	} counts_t;

	// line-major, index 0 is lag 1.
	typedef struct packed {
		logic [0:`CORR_LINES-1][0:`CORR_LAGS-1][`CORR_RES-1:0] acc;
	} lags_t;

	typedef struct packed {
		logic [7:0] hdr;
		counts_t    counts;
		lags_t      lags;
	} frame_t;

endpackage

`default_nettype wire

// ==== logic/cmd_parser.sv ====
// Command byte decoder.
// Holds the masks and the integrating level, pulses clear and send.
`default_nettype none

module cmd_parser (
	input  wire logic         intclk,
	input  wire logic         arst_n,
	input  wire logic [7:0]   cmd_byte,
	input  wire logic         cmd_strobe,
	output corr_pkg::ctrl_t   ctrl
);

	localparam logic [3:0] OP_INVERT = 4'h1;
	localparam logic [3:0] OP_EDGE   = 4'h2;
	localparam logic [3:0] OP_START  = 4'h3;
	localparam logic [3:0] OP_STOP   = 4'h4;

	logic [3:0] opcode;
	logic [3:0] arg;

	assign opcode = cmd_byte[7:4];
	assign arg    = cmd_byte[3:0];

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
		end else begin
			ctrl.clear <= 1'b0; // pulses last one cycle.
			ctrl.send  <= 1'b0;
			if (cmd_strobe) begin
				case (opcode)
					OP_INVERT: begin
						ctrl.inv_mask <= arg;
					end
					OP_EDGE: begin
						ctrl.edge_mask <= arg;
					end
					OP_START: begin
						ctrl.clear       <= 1'b1;
						ctrl.integrating <= 1'b1;
					end
					OP_STOP: begin
						ctrl.integrating <= 1'b0;
						ctrl.send        <= 1'b1;
					end
					default: begin
						// unknown opcode, nothing changes.
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/line_conditioner.sv ====
// Input line register with inversion, edge detection and gating.
`include "corr_defs.svh"
`default_nettype none

module line_conditioner (
	input  wire logic                   intclk,
	input  wire logic                   arst_n,
	input  wire logic [`CORR_LINES-1:0] line_in,
	input  corr_pkg::ctrl_t             ctrl,
	output corr_pkg::sample_t           sample
);

	logic [`CORR_LINES-1:0] inv_line;
	logic [`CORR_LINES-1:0] prev_line;
	logic [`CORR_LINES-1:0] change;

	assign inv_line = line_in ^ ctrl.inv_mask;
	assign change   = inv_line ^ prev_line;

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			prev_line <= '0;
			sample    <= '0;
		end else begin
			prev_line   <= inv_line; // kept whether gated or not.
			sample.bits <= (inv_line & ~ctrl.edge_mask) | (change & ctrl.edge_mask);
			sample.gate <= ctrl.integrating;
		end
	end

endmodule

`default_nettype wire

// ==== logic/pulse_counter.sv ====
// Saturating per-line counters of active gated samples.
`include "corr_defs.svh"
`default_nettype none

module pulse_counter (
	input  wire logic          intclk,
	input  wire logic          arst_n,
	input  corr_pkg::sample_t  sample,
	input  wire logic          clear,
	output corr_pkg::counts_t  counts
);

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			counts <= '0;
		end else if (clear) begin
			counts <= '0;
		end else if (sample.gate) begin
			for (int i = 0; i < `CORR_LINES; i++) begin
				if (sample.bits[i] && counts.cnt[i] != '1) begin
					counts.cnt[i] <= counts.cnt[i] + 1'b1; // stops at all ones.
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/lag_correlator.sv ====
// Per-line sample history and lag 1 to CORR_LAGS autocorrelation.
// Accumulators saturate at all ones.
`include "corr_defs.svh"
`default_nettype none

module lag_correlator (
	input  wire logic          intclk,
	input  wire logic          arst_n,
	input  corr_pkg::sample_t  sample,
	input  wire logic          clear,
	output corr_pkg::lags_t    lags
);

	// hist[i][k] holds line i as it was k+1 samples ago.
	logic [`CORR_LINES-1:0][`CORR_LAGS-1:0] hist;

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			hist <= '0;
		end else if (clear) begin
			hist <= '0;
		end else begin
			for (int i = 0; i < `CORR_LINES; i++) begin
				hist[i] <= {hist[i][`CORR_LAGS-2:0], sample.bits[i]}; // every sample.
			end
		end
	end

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			lags <= '0;
		end else if (clear) begin
			lags <= '0;
		end else if (sample.gate) begin
			for (int i = 0; i < `CORR_LINES; i++) begin
				for (int k = 0; k < `CORR_LAGS; k++) begin
					if (sample.bits[i] && hist[i][k] && lags.acc[i][k] != '1) begin
						lags.acc[i][k] <= lags.acc[i][k] + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/packet_tx.sv ====
// Frame latch and nibble shifter.
// Sends header, counts and lags, most significant nibble first.
`include "corr_defs.svh"
`default_nettype none

module packet_tx (
	input  wire logic          intclk,
	input  wire logic          arst_n,
	input  wire logic          send,
	input  corr_pkg::counts_t  counts,
	input  corr_pkg::lags_t    lags,
	output logic [3:0]         nib,
	output logic               nib_valid,
	output logic               busy
);

	localparam int FW   = $bits(corr_pkg::frame_t);
	localparam int NIBS = FW / 4;

	corr_pkg::frame_t frame_now;
	logic [FW-1:0]    frame_vec;
	logic [FW-1:0]    shreg;
	logic [6:0]       left; // nibbles still to go after this one.
	logic             load;

	assign frame_now.hdr    = `CORR_HDR;
	assign frame_now.counts = counts;
	assign frame_now.lags   = lags;
	assign frame_vec        = frame_now;

	// header leads while the accumulators take their last sample.
	assign nib = load ? frame_vec[FW-1 -: 4] : shreg[FW-1 -: 4];

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			nib_valid <= 1'b0;
			load      <= 1'b0;
			left      <= '0;
		end else begin
			load <= 1'b0;
			if (!busy) begin
				if (send) begin
					busy      <= 1'b1;
					nib_valid <= 1'b1;
					load      <= 1'b1;
					left      <= 7'(NIBS - 1);
				end
			end else if (left == '0) begin
				busy      <= 1'b0; // last nibble done.
				nib_valid <= 1'b0;
			end else begin
				left <= left - 1'b1;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (load) begin
			shreg <= {frame_vec[FW-5:0], 4'h0}; // first nibble already out.
		end else if (busy) begin
			shreg <= {shreg[FW-5:0], 4'h0};
		end
	end

endmodule

`default_nettype wire

// ==== logic/correlator_top.sv ====
// Pulse correlator top level.
// Command decoder, line conditioner, accumulators and nibble transmitter.
`include "corr_defs.svh"
`default_nettype none

module correlator_top (
	input  wire logic                   intclk,
	input  wire logic                   arst_n,
	input  wire logic [`CORR_LINES-1:0] line_in,
	input  wire logic [7:0]             cmd_byte,
	input  wire logic                   cmd_strobe,
	output logic [3:0]                  nib,
	output logic                        nib_valid,
	output logic                        busy
);

	corr_pkg::ctrl_t   ctrl;
	corr_pkg::sample_t sample;
	corr_pkg::counts_t counts;
	corr_pkg::lags_t   lags;

	cmd_parser i_cmd_parser (
		.intclk     (intclk),
		.arst_n     (arst_n),
		.cmd_byte   (cmd_byte),
		.cmd_strobe (cmd_strobe),
		.ctrl       (ctrl)
	);

	line_conditioner i_line_conditioner (
		.intclk  (intclk),
		.arst_n  (arst_n),
		.line_in (line_in),
		.ctrl    (ctrl),
		.sample  (sample)
	);

	pulse_counter i_pulse_counter (
		.intclk (intclk),
		.arst_n (arst_n),
		.sample (sample),
		.clear  (ctrl.clear),
		.counts (counts)
	);

	lag_correlator i_lag_correlator (
		.intclk (intclk),
		.arst_n (arst_n),
		.sample (sample),
		.clear  (ctrl.clear),
		.lags   (lags)
	);

	packet_tx i_packet_tx (
		.intclk    (intclk),
		.arst_n    (arst_n),
		.send      (ctrl.send),
		.counts    (counts),
		.lags      (lags),
		.nib       (nib),
		.nib_valid (nib_valid),
		.busy      (busy)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Free-running 20 ns clock and power-on reset for the testbench.
`default_nettype none

module tb_clock (
	output logic intclk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		intclk = 1'b0;
		forever #10 intclk = ~intclk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge intclk);
		@(negedge intclk);
		arst_n = 1'b1; // released between active edges.
	end

endmodule

`default_nettype wire

// ==== tb/corr_properties.sv ====
// Concurrent assertions on the nibble transmitter.
// Bound into packet_tx from the testbench top.
`default_nettype none

module corr_properties (
	input wire logic intclk,
	input wire logic arst_n,
	input wire logic send,
	input wire logic nib_valid,
	input wire logic busy
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	valid_needs_busy: assert property (@(posedge intclk) disable iff (!arst_n)
		nib_valid |-> busy)
		else begin
			$error("nib_valid high while busy is low");
			fail_count++;
		end

	send_starts_frame: assert property (@(posedge intclk) disable iff (!arst_n)
		(send && !busy) |=> busy)
		else begin
			$error("send while idle did not raise busy");
			fail_count++;
		end

	quiet_in_reset: assert property (@(posedge intclk) !arst_n |-> !nib_valid)
		else begin
			$error("nib_valid high during reset");
			fail_count++;
		end

endmodule

`default_nettype wire

// ==== tb/corr_checker.sv ====
// Reference model and nibble checker for the correlator.
// Follows commands and lines, builds the expected frame, compares every nibble.
`include "corr_defs.svh"
`default_nettype none

module corr_checker (
	input  wire logic                   intclk,
	input  wire logic                   arst_n,
	input  wire logic [`CORR_LINES-1:0] line_in,
	input  wire logic [7:0]             cmd_byte,
	input  wire logic                   cmd_strobe,
	input  wire logic [3:0]             nib,
	input  wire logic                   nib_valid,
	input  wire logic                   busy,
	input  wire logic [7:0]             test_id,
	input  wire logic                   test_done,
	input  wire logic                   report,
	output int                          errors
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FW   = $bits(corr_pkg::frame_t);
	localparam int NIBS = FW / 4;

	logic [`CORR_LINES-1:0] inv_mask;
	logic [`CORR_LINES-1:0] edge_mask;
	logic [`CORR_LINES-1:0] prev;
	logic [`CORR_LINES-1:0] cond;
	logic                   integ;
	logic                   started;
	logic [`CORR_LINES-1:0] smp_mem [0:1023]; // gated samples since start.
	int                     smp_n;
	logic [3:0]             exp_q [$];
	logic [FW-1:0]          fv;
	int err_cnt = 0;
	int test_errs = 0;
	int test_nibs = 0;
	int all_nibs = 0;
	int frames = 0;
	int n_tests = 0;

	assign errors = err_cnt;

	function automatic logic [`CORR_RES-1:0] saturate(input int v);
		return (v >= (1 << `CORR_RES)) ? '1 : v[`CORR_RES-1:0];
	endfunction

	// counts and lag products over the first n gated samples.
	function automatic corr_pkg::frame_t ref_frame(input int n);
		corr_pkg::frame_t f;
		int cnt;
		int acc;
		f.hdr = `CORR_HDR;
		for (int i = 0; i < `CORR_LINES; i++) begin
			cnt = 0;
			for (int j = 0; j < n; j++) begin
				if (smp_mem[j][i]) cnt++;
			end
			f.counts.cnt[i] = saturate(cnt);
			for (int k = 1; k <= `CORR_LAGS; k++) begin
				acc = 0;
				for (int j = k; j < n; j++) begin
					if (smp_mem[j][i] && smp_mem[j-k][i]) acc++;
				end
				f.lags.acc[i][k-1] = saturate(acc);
			end
		end
		return f;
	endfunction

	always @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			inv_mask  = '0;
			edge_mask = '0;
			prev      = '0;
			integ     = 1'b0;
			started   = 1'b0;
			smp_n     = 0;
			exp_q.delete();
		end else begin
			// masks in force before this edge.
			for (int i = 0; i < `CORR_LINES; i++) begin
				cond[i] = line_in[i] ^ inv_mask[i];
				if (edge_mask[i]) begin
					cond[i] = (cond[i] != prev[i]); // changed since last sample.
				end
			end
			prev = line_in ^ inv_mask;
			if (integ && smp_n < 1024) begin
				smp_mem[smp_n] = cond;
				smp_n++;
			end
			if (busy !== nib_valid) begin
				$display("mismatch at %0t: busy is %b while nib_valid is %b",
					$time, busy, nib_valid);
				err_cnt++;
				test_errs++;
			end
			if (nib_valid) begin
				test_nibs++;
				all_nibs++;
				if (exp_q.size() == 0) begin
					$display("extra nibble at %0t outside any frame", $time);
					err_cnt++;
					test_errs++;
				end else begin
					if (nib !== exp_q[0]) begin
						$display("mismatch at %0t: nibble %0d of frame %0d is %h, expected %h",
							$time, NIBS - exp_q.size(), frames, nib, exp_q[0]);
						err_cnt++;
						test_errs++;
					end
					void'(exp_q.pop_front());
					started = (exp_q.size() != 0);
				end
			end else if (started) begin
				$display("frame %0d broke off at %0t with %0d nibbles missing",
					frames, $time, exp_q.size());
				err_cnt++;
				test_errs++;
				exp_q.delete();
				started = 1'b0;
			end
			if (cmd_strobe) begin
				case (cmd_byte[7:4])
					4'h1: inv_mask = cmd_byte[3:0];
					4'h2: edge_mask = cmd_byte[3:0];
					4'h3: begin
						integ = 1'b1;
						smp_n = 0;
					end
					4'h4: begin
						integ = 1'b0;
						if (exp_q.size() == 0) begin // a stop during a frame is dropped.
							fv = ref_frame(smp_n);
							frames++;
							for (int j = 0; j < NIBS; j++) begin
								exp_q.push_back(fv[FW-1-4*j -: 4]);
							end
						end
					end
					default: ;
				endcase
			end
			if (test_done) begin
				if (exp_q.size() != 0) begin
					$display("%0d nibbles of frame %0d never arrived", exp_q.size(), frames);
					err_cnt++;
					test_errs++;
					exp_q.delete();
					started = 1'b0;
				end
				$display("test %0d finished: %0d nibbles, %0d errors",
					test_id, test_nibs, test_errs);
				n_tests++;
				test_nibs = 0;
				test_errs = 0;
			end
		end
	end

	always @(posedge report) begin
		$display("tests %0d, frames %0d, nibbles %0d, errors %0d",
			n_tests, frames, all_nibs, err_cnt);
	end

endmodule

`default_nettype wire

// ==== tb/tb_correlator.sv ====
// Testbench top for the pulse correlator.
// Clock, DUT, checker, bound assertions and the test sequence.
`include "corr_defs.svh"
`default_nettype none

module tb_correlator;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS = 6;
	localparam int INTEG_LEN = 200;

	logic                   intclk;
	logic                   arst_n;
	logic [`CORR_LINES-1:0] line_in = '0;
	logic [7:0]             cmd_byte = '0;
	logic                   cmd_strobe = 1'b0;
	logic [3:0]             nib;
	logic                   nib_valid;
	logic                   busy;
	logic [7:0]             test_id = '0;
	logic                   test_done = 1'b0;
	logic                   report = 1'b0;
	int                     errors;
	int                     wait_fails = 0;
	logic [31:0]            lfsr = 32'h3d60;

	bind packet_tx corr_properties i_corr_properties (.intclk(intclk), .arst_n(arst_n),
		.send(send), .nib_valid(nib_valid), .busy(busy));

	tb_clock i_tb_clock (.intclk(intclk), .arst_n(arst_n));

	correlator_top i_correlator_top (
		.intclk     (intclk),
		.arst_n     (arst_n),
		.line_in    (line_in),
		.cmd_byte   (cmd_byte),
		.cmd_strobe (cmd_strobe),
		.nib        (nib),
		.nib_valid  (nib_valid),
		.busy       (busy)
	);

	corr_checker i_corr_checker (
		.intclk     (intclk),
		.arst_n     (arst_n),
		.line_in    (line_in),
		.cmd_byte   (cmd_byte),
		.cmd_strobe (cmd_strobe),
		.nib        (nib),
		.nib_valid  (nib_valid),
		.busy       (busy),
		.test_id    (test_id),
		.test_done  (test_done),
		.report     (report),
		.errors     (errors)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic drive_lines(input int n);
		repeat (n) begin
			@(negedge intclk);
			for (int i = 0; i < `CORR_LINES; i++) begin
				line_in[i] = lfsr[0];
				lfsr = lfsr_next(lfsr);
			end
		end
	endtask

	task automatic send_cmd(input logic [7:0] b);
		@(negedge intclk);
		cmd_byte = b;
		cmd_strobe = 1'b1;
		@(negedge intclk);
		cmd_strobe = 1'b0;
	endtask

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		while (busy !== level && n < 200) begin
			@(negedge intclk);
			n++;
		end
		if (busy !== level) begin
			$display("timeout waiting for busy to go %b", level);
			wait_fails++;
		end
	endtask

	task automatic integrate(input int n);
		send_cmd(8'h30);
		drive_lines(n);
		send_cmd(8'h40);
		wait_busy(1'b1);
		wait_busy(1'b0);
	endtask

	task automatic end_test(input logic [7:0] id);
		@(negedge intclk);
		test_id = id;
		test_done = 1'b1;
		@(negedge intclk);
		test_done = 1'b0;
	endtask

	initial begin
		@(posedge arst_n);
		drive_lines(50);
		end_test(8'd1);
		send_cmd(8'h7F); // unknown opcode.
		integrate(INTEG_LEN);
		end_test(8'd2);
		send_cmd(8'h15);
		integrate(INTEG_LEN);
		end_test(8'd3);
		send_cmd(8'h10);
		send_cmd(8'h23);
		integrate(INTEG_LEN);
		end_test(8'd4);
		send_cmd(8'h20);
		send_cmd(8'h30);
		drive_lines(INTEG_LEN);
		send_cmd(8'h40);
		wait_busy(1'b1);
		drive_lines(20);
		send_cmd(8'h40); // lands mid frame.
		wait_busy(1'b0);
		drive_lines(10);
		end_test(8'd5);
		send_cmd(8'h30);
		drive_lines(50);
		integrate(INTEG_LEN - 50); // restart clears the first run.
		end_test(8'd6);
		@(negedge intclk);
		report = 1'b1;
		@(posedge intclk);
		#1;
		if (errors == 0 && wait_fails == 0 &&
			i_correlator_top.i_packet_tx.i_corr_properties.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(NUM_TESTS * (INTEG_LEN + 100) * 20);
		$display("watchdog expired before the test sequence finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/corr_pkg.sv
logic/cmd_parser.sv
logic/line_conditioner.sv
logic/pulse_counter.sv
logic/lag_correlator.sv
logic/packet_tx.sv
logic/correlator_top.sv
tb/tb_clock.sv
tb/corr_properties.sv
tb/corr_checker.sv
tb/tb_correlator.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module tb_correlator -o Vtb_correlator
	./obj_dir/Vtb_correlator | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
